// ==== hw/main_bus_cfg.svh ====
// address map, CPU clock enable and EEPROM timing constants, included by the bus RTL
`ifndef MAIN_BUS_CFG_SVH
`define MAIN_BUS_CFG_SVH

// clk cycles per CPU clock enable
`define MB_CEN_DIV 3

// serial EEPROM
`define MB_EEP_WR_CYCLES 64 // busy time after a write, in clk cycles
`define MB_EEP_AW 7

// regions, address bits 23 to 20
`define MB_PAGE_ROM  4'h0
`define MB_PAGE_SYS  4'h1
`define MB_PAGE_SND  4'h5
`define MB_PAGE_VRAM 4'h6

// subpages of the system region, bits 19 to 18
`define MB_SUB_RAM 2'd0
`define MB_SUB_PAL 2'd1
`define MB_SUB_OBJ 2'd2
`define MB_SUB_IO  2'd3

// I/O page registers, bits 10 to 8
`define MB_REG_CAB  3'd0
`define MB_REG_DIP  3'd1
`define MB_REG_IOLO 3'd2
`define MB_REG_IOHI 3'd3

// sound region, bits 19 to 16 then bits 11 to 8
`define MB_SND_PAGE 4'hc
`define MB_REG_SND  4'h6
`define MB_REG_PCU  4'h7

`endif

// ==== hw/main_bus_pkg.sv ====
// shared struct types of the main CPU bus glue, referenced by scoped name
package main_bus_pkg;

    // request from the bus master
    typedef struct packed {
        logic [23:1] addr;  // word address
        logic        as_n;
        logic        uds_n;
        logic        lds_n;
        logic        rnw;
        logic [15:0] wdata;
    } bus_req_t;

    // device strobes, at most one high
    typedef struct packed {
        logic rom;
        logic ram;
        logic pal;
        logic obj;
        logic vram;
        logic snd;
        logic sndon;    // sound irq trigger
        logic pcu;
        logic cab;
        logic dip;
        logic iowr_lo;
        logic iowr_hi;
    } dev_sel_t;

    // read data coming back from the external chips
    typedef struct packed {
        logic [15:0] rom;
        logic [15:0] ram;
        logic [15:0] pal;
        logic [ 7:0] oram;
        logic [ 7:0] vram;
        logic [ 7:0] snd;
    } dev_rdata_t;

    // two player cabinet
    typedef struct packed {
        logic [6:0] joy1;
        logic [6:0] joy2;
        logic [1:0] start;
        logic [1:0] coin;
        logic       service;
    } cab_in_t;

    typedef struct packed {
        logic [2:0] cbnk;   // colour bank
        logic       dimpol;
        logic       dimmod;
        logic [2:0] dim;
        logic       rmrd;
    } vid_cfg_t;

    typedef struct packed {
        logic sclk;
        logic scs;  // active high
        logic sdi;
    } eep_pins_t;

endpackage

// ==== hw/main_addr_dec.sv ====
// combinational address decoder turning a bus request into device and register strobes
`timescale 1ns/100ps
`include "main_bus_cfg.svh"

module main_addr_dec (
    input  main_bus_pkg::bus_req_t req,
    output main_bus_pkg::dev_sel_t sel
);

    always_comb begin
        sel = '0;
        if (!req.as_n) begin // nothing selected outside an access
            case (req.addr[23:20])
                `MB_PAGE_ROM: sel.rom = 1'b1;
                `MB_PAGE_SYS: begin
                    case (req.addr[19:18])
                        `MB_SUB_RAM: sel.ram = 1'b1;
                        `MB_SUB_PAL: sel.pal = 1'b1;
                        `MB_SUB_OBJ: sel.obj = 1'b1; // object RAM, byte wide
                        `MB_SUB_IO: begin
                            if (!req.addr[11]) begin
                                case (req.addr[10:8])
                                    `MB_REG_CAB:  sel.cab     = 1'b1;
                                    `MB_REG_DIP:  sel.dip     = 1'b1;
                                    `MB_REG_IOLO: sel.iowr_lo = 1'b1; // dimming and EEPROM pins
                                    `MB_REG_IOHI: sel.iowr_hi = 1'b1;
                                    default: ;
                                endcase
                            end
                        end
                        default: ;
                    endcase
                end
                `MB_PAGE_SND: begin
                    if (req.addr[19:16] == `MB_SND_PAGE) begin
                        case (req.addr[11:8])
                            `MB_REG_SND: begin
                                // A2 splits data access from irq trigger
                                sel.snd   = !req.addr[2];
                                sel.sndon = req.addr[2];
                            end
                            `MB_REG_PCU: sel.pcu = 1'b1;
                            default: ;
                        endcase
                    end
                end
                `MB_PAGE_VRAM: sel.vram = 1'b1;
                default: ;
            endcase
        end
    end

endmodule

// ==== hw/main_dtack_gen.sv ====
// CPU clock enable divider and data acknowledge generator, waits on slow memory
`timescale 1ns/100ps
`include "main_bus_cfg.svh"

module main_dtack_gen (
    input  logic                   clk,
    input  logic                   rst,
    input  main_bus_pkg::bus_req_t req,
    input  main_bus_pkg::dev_sel_t sel,
    input  logic                   rom_ok,
    input  logic                   ram_ok,
    input  logic                   vdtac,
    output logic                   cpu_cen,
    output logic                   dtack_n
);

    localparam int CNT_W = $clog2(`MB_CEN_DIV);

    logic [CNT_W-1:0] cen_cnt;
    logic             one_period;   // an enable already seen with the device ready
    logic             dev_rdy;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cen_cnt <= '0;
        end else begin
            cen_cnt <= cpu_cen ? '0 : cen_cnt + 1'b1;
        end
    end

    assign cpu_cen = cen_cnt == CNT_W'(`MB_CEN_DIV - 1);

    // readiness of whatever the address points at
    always_comb begin
        if (sel.rom || sel.ram) begin
            dev_rdy = (sel.rom && rom_ok) || (sel.ram && ram_ok);
        end else if (sel.vram) begin
            dev_rdy = vdtac;
        end else begin
            dev_rdy = 1'b1; // registers and unmapped space answer at once
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            one_period <= 1'b0;
            dtack_n    <= 1'b1;
        end else if (req.as_n) begin
            // end of access releases the acknowledge
            one_period <= 1'b0;
            dtack_n    <= 1'b1;
        end else if (!dev_rdy) begin
            one_period <= 1'b0; // restart the wait once the device stalls
        end else if (cpu_cen) begin
            one_period <= 1'b1;
            if (one_period) begin
                dtack_n <= 1'b0;
            end
        end
    end

endmodule

// ==== hw/cab_input_mux.sv ====
// registered cabinet and DIP switch read words, selected by the low address bits
`timescale 1ns/100ps

module cab_input_mux (
    input  logic                   clk,
    input  main_bus_pkg::bus_req_t req,
    input  main_bus_pkg::dev_sel_t sel,
    input  main_bus_pkg::cab_in_t  cab,
    input  logic [15:0]            dipsw,
    input  logic                   eep_rdy,
    input  logic                   eep_do,
    output logic [15:0]            cab_dout
);

    always_ff @(posedge clk) begin
        cab_dout[15:8] <= 8'h00; // byte wide port
        if (sel.dip) begin
            case (req.addr[2:1])
                2'd0: cab_dout[7:0] <= dipsw[7:0];
                2'd1: cab_dout[7:0] <= dipsw[15:8];
                2'd2: cab_dout[7:0] <= {6'h3f, eep_rdy, eep_do}; // EEPROM status
                2'd3: cab_dout[7:0] <= 8'h00;
                default: cab_dout[7:0] <= 8'h00;
            endcase
        end else begin
            case (req.addr[2:1])
                2'd0: begin
                    cab_dout[7:0] <= {1'b1, cab.service, 1'b1, cab.start[1], cab.start[0],
                                      1'b1, cab.coin[1], cab.coin[0]};
                end
                2'd1: cab_dout[7:0] <= {cab.start[0], cab.joy1};
                2'd2: cab_dout[7:0] <= {cab.start[1], cab.joy2};
                2'd3: cab_dout[7:0] <= 8'hff; // no third player
                default: cab_dout[7:0] <= 8'hff;
            endcase
        end
    end

endmodule

// ==== hw/sys_io_latch.sv ====
// write-only system registers for video dimming, colour bank and the EEPROM serial pins
`timescale 1ns/100ps

module sys_io_latch (
    input  logic                    clk,
    input  logic                    rst,
    input  main_bus_pkg::bus_req_t  req,
    input  main_bus_pkg::dev_sel_t  sel,
    output main_bus_pkg::vid_cfg_t  vid,
    output main_bus_pkg::eep_pins_t eep
);

    logic wr_lo;
    logic wr_hi;

    assign wr_lo = sel.iowr_lo && !req.rnw;
    assign wr_hi = sel.iowr_hi && !req.rnw;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vid <= '0;
            eep <= '0;
        end else begin
            if (wr_lo) begin
                vid.cbnk   <= req.wdata[7:5];
                vid.dimpol <= req.wdata[4];
                vid.dimmod <= req.wdata[3];
                eep.sclk   <= req.wdata[2]; // bit banged serial pins
                eep.scs    <= req.wdata[1];
                eep.sdi    <= req.wdata[0];
            end
            if (wr_hi) begin
                vid.dim  <= req.wdata[6:4];
                vid.rmrd <= req.wdata[3]; // object ROM readback
            end
        end
    end

endmodule

// ==== hw/serial_eeprom.sv ====
// 93C46 style serial EEPROM of 128 bytes, bit banged by the CPU through the system latch
`timescale 1ns/100ps
`include "main_bus_cfg.svh"

module serial_eeprom (
    input  logic                    clk,
    input  logic                    rst,
    input  main_bus_pkg::eep_pins_t pins,
    output logic                    sdo,
    output logic                    rdy
);

    localparam int AW     = `MB_EEP_AW;
    localparam int DEPTH  = 1 << AW;
    localparam int BUSY_W = $clog2(`MB_EEP_WR_CYCLES + 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_READ,
        ST_WRITE
    } ee_state_t;

    ee_state_t         state;
    logic              sclk_q;
    logic              sclk_rise;
    logic [AW:0]       cmd_sr;      // opcode and address bits so far
    logic [AW+1:0]     cmd_full;
    logic [3:0]        bit_cnt;
    logic [AW-1:0]     ee_addr;
    logic [6:0]        din_sr;      // first seven data bits
    logic [8:0]        dout_sr;     // dummy zero ahead of the data byte
    logic              wen;
    logic [BUSY_W-1:0] busy_cnt;
    logic [7:0]        mem [DEPTH];

    assign sclk_rise = pins.sclk && !sclk_q;
    assign cmd_full  = {cmd_sr, pins.sdi};
    assign sdo       = dout_sr[8];
    assign rdy       = busy_cnt == '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= ST_IDLE;
            sclk_q   <= 1'b0;
            cmd_sr   <= '0;
            bit_cnt  <= '0;
            ee_addr  <= '0;
            din_sr   <= '0;
            dout_sr  <= '0;
            wen      <= 1'b0;
            busy_cnt <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= 8'hff; // blank part
            end
        end else begin
            sclk_q <= pins.sclk;
            if (busy_cnt != '0) begin
                busy_cnt <= busy_cnt - 1'b1;
            end
            if (!pins.scs) begin
                // deselect aborts any command
                state   <= ST_IDLE;
                bit_cnt <= '0;
                dout_sr <= '0;
            end else if (sclk_rise) begin
                case (state)
                    ST_IDLE: begin
                        if (pins.sdi && rdy) begin // start bit
                            state   <= ST_ADDR;
                            bit_cnt <= '0;
                        end
                    end
                    ST_ADDR: begin
                        cmd_sr  <= cmd_full[AW:0];
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 4'(AW + 1)) begin
                            bit_cnt <= '0;
                            ee_addr <= cmd_full[AW-1:0];
                            case (cmd_full[AW+1:AW])
                                2'b10: begin
                                    state   <= ST_READ;
                                    dout_sr <= {1'b0, mem[cmd_full[AW-1:0]]};
                                end
                                2'b01: state <= ST_WRITE;
                                2'b00: begin
                                    if (cmd_full[AW-1:AW-2] == 2'b11) begin
                                        wen <= 1'b1; // EWEN
                                    end
                                    state <= ST_IDLE;
                                end
                                default: state <= ST_IDLE; // erase not supported
                            endcase
                        end
                    end
                    ST_READ: dout_sr <= {dout_sr[7:0], 1'b0}; // MSB first
                    ST_WRITE: begin
                        din_sr  <= {din_sr[5:0], pins.sdi};
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 4'd7) begin
                            if (wen) begin
                                mem[ee_addr] <= {din_sr, pins.sdi};
                                busy_cnt     <= BUSY_W'(`MB_EEP_WR_CYCLES);
                            end
                            state <= ST_IDLE;
                        end
                    end
                    default: state <= ST_IDLE;
                endcase
            end
        end
    end

endmodule

// ==== hw/main_bus.sv ====
// top level of the main CPU bus glue, wires the decode, acknowledge, I/O and EEPROM blocks
`timescale 1ns/100ps

module main_bus (
    input  logic                     clk,
    input  logic                     rst,
    input  main_bus_pkg::bus_req_t   req,
    input  logic                     rom_ok,
    input  logic                     ram_ok,
    input  logic                     vdtac,
    input  main_bus_pkg::dev_rdata_t dev,
    input  main_bus_pkg::cab_in_t    cab,
    input  logic [15:0]              dipsw,
    output main_bus_pkg::dev_sel_t   sel,
    output logic [15:0]              rdata,
    output logic                     dtack_n,
    output logic                     cpu_cen,
    output main_bus_pkg::vid_cfg_t   vid
);

    main_bus_pkg::eep_pins_t eep;
    logic                    eep_do;
    logic                    eep_rdy;
    logic [15:0]             cab_dout;

    main_addr_dec i_addr_dec (
        .req (req),
        .sel (sel)
    );

    main_dtack_gen i_dtack_gen (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .sel     (sel),
        .rom_ok  (rom_ok),
        .ram_ok  (ram_ok),
        .vdtac   (vdtac),
        .cpu_cen (cpu_cen),
        .dtack_n (dtack_n)
    );

    cab_input_mux i_cab_input_mux (
        .clk      (clk),
        .req      (req),
        .sel      (sel),
        .cab      (cab),
        .dipsw    (dipsw),
        .eep_rdy  (eep_rdy),
        .eep_do   (eep_do),
        .cab_dout (cab_dout)
    );

    sys_io_latch i_sys_io_latch (
        .clk (clk),
        .rst (rst),
        .req (req),
        .sel (sel),
        .vid (vid),
        .eep (eep)
    );

    serial_eeprom i_serial_eeprom (
        .clk  (clk),
        .rst  (rst),
        .pins (eep),
        .sdo  (eep_do),
        .rdy  (eep_rdy)
    );

    // read data back to the CPU, byte wide chips show on both halves
    always_ff @(posedge clk) begin
        if (sel.rom) begin
            rdata <= dev.rom;
        end else if (sel.ram) begin
            rdata <= dev.ram;
        end else if (sel.obj) begin
            rdata <= {2{dev.oram}};
        end else if (sel.vram) begin
            rdata <= {2{dev.vram}};
        end else if (sel.pal) begin
            rdata <= dev.pal;
        end else if (sel.snd) begin
            rdata <= {8'h00, dev.snd};
        end else if (sel.cab || sel.dip) begin
            rdata <= cab_dout;
        end else begin
            rdata <= 16'hffff; // open bus
        end
    end

endmodule

// ==== dv/main_bus_asserts.sv ====
// concurrent checks on the acknowledge, the strobes and the video latch, bound into main_bus
`timescale 1ns/100ps

module main_bus_asserts (
    input logic                   clk,
    input logic                   rst,
    input main_bus_pkg::bus_req_t req,
    input main_bus_pkg::dev_sel_t sel,
    input logic                   rom_ok,
    input logic                   dtack_n,
    input main_bus_pkg::vid_cfg_t vid
);

    // acknowledge released once the strobe ends
    dtack_release: assert property (@(posedge clk) disable iff (rst) req.as_n |=> dtack_n)
        else $error("dtack_n still low in the cycle after as_n went high");

    one_strobe: assert property (@(posedge clk) disable iff (rst) $onehot0(sel))
        else $error("more than one device strobe high");

    // slow ROM holds off the acknowledge
    rom_wait: assert property (@(posedge clk) disable iff (rst)
        $fell(dtack_n) |-> !$past(sel.rom) || $past(rom_ok))
        else $error("dtack_n fell for rom while rom_ok was low");

    vid_write_only: assert property (@(posedge clk) disable iff (rst)
        !$stable(vid) |-> $past(sel.iowr_lo || sel.iowr_hi))
        else $error("video configuration changed without an iowr strobe");

endmodule

bind main_bus main_bus_asserts i_main_bus_asserts (
    .clk     (clk),
    .rst     (rst),
    .req     (req),
    .sel     (sel),
    .rom_ok  (rom_ok),
    .dtack_n (dtack_n),
    .vid     (vid)
);

// ==== dv/main_bus_tb.sv ====
// testbench for the main CPU bus glue, acts as the 68000 bus master and models the devices
`timescale 1ns/100ps
`include "main_bus_cfg.svh"

module main_bus_tb;

    localparam int CLK_PERIOD = 100;
    localparam int N_ACC      = 1000; // a little above the accesses in the run
    localparam logic [15:0] ROM_KEY  = 16'h0f0f;
    localparam logic [15:0] RAM_KEY  = 16'h3c3c;
    localparam logic [15:0] PAL_KEY  = 16'h5a5a;
    localparam logic [15:0] ORAM_KEY = 16'h0077;
    localparam logic [15:0] VRAM_KEY = 16'h00c3;
    localparam logic [15:0] SND_KEY  = 16'h0019;
    localparam logic [23:0] IOLO_ADDR  = 24'h1c0200;
    localparam logic [23:0] IOHI_ADDR  = 24'h1c0300;
    localparam logic [23:0] DIP_STATUS = 24'h1c0104; // dip page word 2
    localparam logic [23:0] REGION_ADDR [15] = '{
        24'h012344, 24'h10abc0, 24'h141230, 24'h180046, 24'h600a10,
        24'h5c0600, 24'h5c0604, 24'h5c0700, 24'h1c0000, 24'h1c0102,
        24'h200000, 24'h1c0800, 24'h1c0400, 24'h5c0500, 24'hf00000
    };

    logic                     clk;
    logic                     rst;
    main_bus_pkg::bus_req_t   req;
    logic                     rom_ok;
    logic                     ram_ok;
    logic                     vdtac;
    main_bus_pkg::dev_rdata_t dev;
    main_bus_pkg::cab_in_t    cab;
    logic [15:0]              dipsw;
    main_bus_pkg::dev_sel_t   sel;
    logic [15:0]              rdata;
    logic                     dtack_n;
    logic                     cpu_cen;
    main_bus_pkg::vid_cfg_t   vid;

    // expected state kept by the testbench
    main_bus_pkg::vid_cfg_t vid_m;
    logic [7:0]             eep_mem_m [128];
    logic                   eep_wen_m;
    logic                   eep_rdy_m;
    logic                   eep_do_m;
    logic                   dtack_q = 1'b1;
    int                     cen_gap = -1;
    int                     err_rdata = 0;
    int                     err_sel = 0;
    int                     err_vid = 0;
    int                     err_other = 0;
    int                     acc_cnt = 0;

    main_bus i_main_bus (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .rom_ok  (rom_ok),
        .ram_ok  (ram_ok),
        .vdtac   (vdtac),
        .dev     (dev),
        .cab     (cab),
        .dipsw   (dipsw),
        .sel     (sel),
        .rdata   (rdata),
        .dtack_n (dtack_n),
        .cpu_cen (cpu_cen),
        .vid     (vid)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [15:0] mem_word(input logic [23:1] a, input logic [15:0] key);
        return {a[8:1], a[16:9]} ^ key;
    endfunction

    // device contents are fixed functions of the address
    always_comb begin
        dev.rom  = mem_word(req.addr, ROM_KEY);
        dev.ram  = mem_word(req.addr, RAM_KEY);
        dev.pal  = mem_word(req.addr, PAL_KEY);
        dev.oram = 8'(mem_word(req.addr, ORAM_KEY));
        dev.vram = 8'(mem_word(req.addr, VRAM_KEY));
        dev.snd  = 8'(mem_word(req.addr, SND_KEY));
    end

    function automatic main_bus_pkg::dev_sel_t expected_strobes(input logic [23:1] a);
        main_bus_pkg::dev_sel_t s;
        s = '0;
        case (a[23:20])
            4'h0: s.rom = 1'b1;
            4'h1: begin
                case (a[19:18])
                    2'd0: s.ram = 1'b1;
                    2'd1: s.pal = 1'b1;
                    2'd2: s.obj = 1'b1;
                    default: begin
                        s.cab     = !a[11] && a[10:8] == 3'd0;
                        s.dip     = !a[11] && a[10:8] == 3'd1;
                        s.iowr_lo = !a[11] && a[10:8] == 3'd2;
                        s.iowr_hi = !a[11] && a[10:8] == 3'd3;
                    end
                endcase
            end
            4'h5: begin
                s.snd   = a[19:16] == 4'hc && a[11:8] == 4'h6 && !a[2];
                s.sndon = a[19:16] == 4'hc && a[11:8] == 4'h6 && a[2];
                s.pcu   = a[19:16] == 4'hc && a[11:8] == 4'h7;
            end
            4'h6: s.vram = 1'b1;
            default: ;
        endcase
        return s;
    endfunction

    function automatic logic [15:0] cabinet_word(input logic [1:0] w, input logic dip_page);
        logic [7:0] b;
        if (dip_page) begin
            case (w)
                2'd0: b = dipsw[7:0];
                2'd1: b = dipsw[15:8];
                2'd2: b = {6'h3f, eep_rdy_m, eep_do_m};
                default: b = 8'h00;
            endcase
        end else begin
            case (w)
                2'd0: b = {1'b1, cab.service, 1'b1, cab.start, 1'b1, cab.coin};
                2'd1: b = {cab.start[0], cab.joy1};
                2'd2: b = {cab.start[1], cab.joy2};
                default: b = 8'hff;
            endcase
        end
        return {8'h00, b};
    endfunction

    function automatic logic [15:0] exp_rdata(input logic [23:1] a);
        main_bus_pkg::dev_sel_t s;
        logic [15:0]            w;
        s = expected_strobes(a);
        if (s.rom) w = mem_word(a, ROM_KEY);
        else if (s.ram) w = mem_word(a, RAM_KEY);
        else if (s.obj) w = {2{8'(mem_word(a, ORAM_KEY))}};
        else if (s.vram) w = {2{8'(mem_word(a, VRAM_KEY))}};
        else if (s.pal) w = mem_word(a, PAL_KEY);
        else if (s.snd) w = {8'h00, 8'(mem_word(a, SND_KEY))};
        else if (s.cab || s.dip) w = cabinet_word(a[2:1], s.dip);
        else w = 16'hffff;
        return w;
    endfunction

    task automatic check_rdata(input logic [15:0] got, input logic [15:0] want);
        if (got !== want) begin
            err_rdata++;
            $display("Fail %0t rdata got %h expected %h", $time, got, want);
        end
    endtask

    task automatic check_sel(input main_bus_pkg::dev_sel_t got,
                             input main_bus_pkg::dev_sel_t want);
        if (got !== want) begin
            err_sel++;
            $display("Fail %0t sel got %b expected %b", $time, got, want);
        end
    endtask

    task automatic check_vid(input main_bus_pkg::vid_cfg_t got,
                             input main_bus_pkg::vid_cfg_t want);
        if (got !== want) begin
            err_vid++;
            $display("Fail %0t vid got %h expected %h", $time, got, want);
        end
    endtask

    // checks every access on the first falling edge with the acknowledge low
    always @(negedge clk) begin
        if (!dtack_n && dtack_q) begin
            check_sel(sel, expected_strobes(req.addr));
            if (req.rnw) begin
                check_rdata(rdata, exp_rdata(req.addr));
            end
        end
        dtack_q = dtack_n;
    end

    // the CPU clock enable is high for one cycle in every MB_CEN_DIV
    always @(negedge clk) begin
        if (rst) begin
            cen_gap = -1;
        end else if (cpu_cen) begin
            if (cen_gap >= 0 && cen_gap != `MB_CEN_DIV - 1) begin
                err_other++;
                $display("cpu_cen pulse came %0d cycles after the previous one", cen_gap + 1);
            end
            cen_gap = 0;
        end else if (cen_gap >= 0) begin
            cen_gap++;
            if (cen_gap == `MB_CEN_DIV) begin
                err_other++;
                $display("cpu_cen missed its pulse at %0t", $time);
            end
        end
    end

    // one bus cycle, slow memory and video RAM ready after random waits
    task automatic run_access(input logic [23:0] ba, input logic rnw, input logic [15:0] wd);
        int rom_wait;
        int ram_wait;
        int vram_wait;
        int cycles;
        rom_wait  = $urandom_range(5, 0);
        ram_wait  = $urandom_range(5, 0);
        vram_wait = $urandom_range(5, 0);
        cycles = 0;
        req.addr  = ba[23:1];
        req.rnw   = rnw;
        req.wdata = wd;
        req.uds_n = 1'b0;
        req.lds_n = 1'b0;
        req.as_n  = 1'b0;
        rom_ok = rom_wait == 0;
        ram_ok = ram_wait == 0;
        vdtac  = vram_wait == 0;
        @(negedge clk);
        while (dtack_n && cycles < 100) begin
            if (rom_wait > 0) rom_wait--;
            if (ram_wait > 0) ram_wait--;
            if (vram_wait > 0) vram_wait--;
            rom_ok = rom_wait == 0;
            ram_ok = ram_wait == 0;
            vdtac  = vram_wait == 0;
            cycles++;
            @(negedge clk);
        end
        if (dtack_n) begin
            err_other++;
            $display("no acknowledge for address %h after %0d cycles", ba, cycles);
        end else if ((sel.rom && !rom_ok) || (sel.ram && !ram_ok) || (sel.vram && !vdtac)) begin
            err_other++;
            $display("acknowledge came before the device was ready at address %h", ba);
        end
        @(negedge clk);
        req.as_n = 1'b1;
        rom_ok   = 1'b0;
        ram_ok   = 1'b0;
        vdtac    = 1'b0;
        acc_cnt++;
        @(negedge clk);
    endtask

    task automatic bus_read(input logic [23:0] ba);
        run_access(ba, 1'b1, 16'h0000);
    endtask

    task automatic bus_write(input logic [23:0] ba, input logic [15:0] wd);
        run_access(ba, 1'b0, wd);
    endtask

    // EEPROM pins share the low system register with the video bits
    task automatic set_pins(input logic sclk, input logic scs, input logic sdi);
        bus_write(IOLO_ADDR, {8'h00, vid_m.cbnk, vid_m.dimpol, vid_m.dimmod, sclk, scs, sdi});
    endtask

    task automatic clock_bit(input logic b);
        set_pins(1'b0, 1'b1, b);
        set_pins(1'b1, 1'b1, b);
    endtask

    task automatic send_command(input logic [1:0] op, input logic [6:0] a);
        logic [9:0] cmd;
        cmd = {1'b1, op, a}; // start bit first
        set_pins(1'b0, 1'b1, 1'b0);
        for (int i = 9; i >= 0; i--) begin
            clock_bit(cmd[i]);
        end
    endtask

    task automatic write_eeprom(input logic [6:0] a, input logic [7:0] d);
        send_command(2'b01, a);
        for (int i = 7; i >= 0; i--) begin
            clock_bit(d[i]);
        end
        set_pins(1'b0, 1'b0, 1'b0);
        if (eep_wen_m) begin
            eep_mem_m[a] = d;
            eep_rdy_m    = 1'b0;
        end
        bus_read(DIP_STATUS); // busy only after an enabled write
        repeat (`MB_EEP_WR_CYCLES) @(negedge clk);
        eep_rdy_m = 1'b1;
        bus_read(DIP_STATUS);
    endtask

    task automatic read_eeprom(input logic [6:0] a);
        send_command(2'b10, a);
        eep_do_m = 1'b0; // dummy bit
        bus_read(DIP_STATUS);
        for (int i = 7; i >= 0; i--) begin
            clock_bit(1'b0);
            eep_do_m = eep_mem_m[a][i];
            bus_read(DIP_STATUS);
        end
        set_pins(1'b0, 1'b0, 1'b0);
        eep_do_m = 1'b0;
    endtask

    initial begin
        #(N_ACC * 40 * CLK_PERIOD);
        $display("watchdog expired after %0d accesses", acc_cnt);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        logic [23:0] ba;
        logic [15:0] d;
        logic [6:0]  ee_addr [6];
        logic [7:0]  ee_data [6];
        void'($urandom(32'h804b));
        req       = '0;
        req.as_n  = 1'b1;
        req.uds_n = 1'b1;
        req.lds_n = 1'b1;
        req.rnw   = 1'b1;
        rom_ok    = 1'b0;
        ram_ok    = 1'b0;
        vdtac     = 1'b0;
        cab       = '0;
        dipsw     = '0;
        vid_m     = '0;
        eep_wen_m = 1'b0;
        eep_rdy_m = 1'b1;
        eep_do_m  = 1'b0;
        for (int i = 0; i < 128; i++) begin
            eep_mem_m[i] = 8'hff;
        end
        rst = 1'b1;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_vid(vid, vid_m);

        // every region once, unmapped ones at the end
        for (int i = 0; i < 15; i++) begin
            bus_read(REGION_ADDR[i]);
        end

        for (int i = 0; i < 40; i++) begin
            ba = 24'($urandom);
            bus_read(i[0] ? {4'h1, 2'b00, ba[17:1], 1'b0} : {4'h0, ba[19:1], 1'b0});
        end

        repeat (8) begin
            cab   = 19'($urandom);
            dipsw = 16'($urandom);
            for (int w = 0; w < 4; w++) begin
                bus_read(24'h1c0000 | {21'd0, 2'(w), 1'b0});
                bus_read(24'h1c0100 | {21'd0, 2'(w), 1'b0});
            end
        end

        repeat (8) begin
            d = 16'($urandom);
            bus_write(IOLO_ADDR, d);
            vid_m.cbnk   = d[7:5];
            vid_m.dimpol = d[4];
            vid_m.dimmod = d[3];
            check_vid(vid, vid_m);
            d = 16'($urandom);
            bus_write(IOHI_ADDR, d);
            vid_m.dim  = d[6:4];
            vid_m.rmrd = d[3];
            check_vid(vid, vid_m);
        end
        bus_read(IOLO_ADDR);
        bus_read(IOHI_ADDR);
        set_pins(1'b0, 1'b0, 1'b0); // EEPROM back to idle

        // writes are locked until EWEN
        write_eeprom(7'h10, 8'h5a);
        read_eeprom(7'h10);

        send_command(2'b00, 7'b1100000);
        set_pins(1'b0, 1'b0, 1'b0);
        eep_wen_m = 1'b1;
        for (int i = 0; i < 6; i++) begin
            ee_addr[i] = 7'($urandom_range(126, 0));
            ee_data[i] = 8'($urandom);
            write_eeprom(ee_addr[i], ee_data[i]);
        end
        for (int i = 0; i < 6; i++) begin
            read_eeprom(ee_addr[i]);
        end
        read_eeprom(7'h7f);
        check_vid(vid, vid_m);

        $display("errors: rdata %0d, sel %0d, vid %0d, other %0d over %0d accesses",
                 err_rdata, err_sel, err_vid, err_other, acc_cnt);
        if (err_rdata + err_sel + err_vid + err_other == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+hw
hw/main_bus_pkg.sv
hw/main_addr_dec.sv
hw/main_dtack_gen.sv
hw/cab_input_mux.sv
hw/sys_io_latch.sv
hw/serial_eeprom.sv
hw/main_bus.sv
dv/main_bus_asserts.sv
dv/main_bus_tb.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, then look for the fail message in the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f tb.f --top-module main_bus_tb -o main_bus_sim \
    && ./obj_dir/main_bus_sim > sim.log 2>&1 \
    || echo "TEST FAILED: build or simulation aborted" >> sim.log
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0
